// ==== common/udp_tx_pkg.sv ====
// shared lengths, limits, register addresses and field types for the UDP transmit path
package udp_tx_pkg;

  // maximum IP datagram size, kept small so the payload clamp can be reached in simulation
  localparam int MTU = 64;

  localparam int IPV4_HDR_LEN = 20;
  localparam int UDP_HDR_LEN  = 8;

  // largest UDP payload that fits into one IP datagram
  localparam int UDP_MAX_PAYLOAD = MTU - IPV4_HDR_LEN - UDP_HDR_LEN;

  // payload bytes held by the input FIFO
  localparam int FIFO_DEPTH = 64;

  // beat counter covers the whole header and the largest payload
  localparam int CTR_W = $clog2(UDP_HDR_LEN + UDP_MAX_PAYLOAD + 1);

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] port_t;
  typedef logic [15:0] len_t;
  typedef logic [15:0] ipv4_id_t;
  typedef logic [2:0]  cfg_addr_t;

  // configuration register map
  localparam cfg_addr_t REG_DEV_IP   = 3'd0;
  localparam cfg_addr_t REG_REM_IP   = 3'd1;
  localparam cfg_addr_t REG_LOC_PORT = 3'd2;
  localparam cfg_addr_t REG_REM_PORT = 3'd3;
  localparam cfg_addr_t REG_LENGTH   = 3'd4;

endpackage

// ==== design/byte_fifo.sv ====
// single-clock byte FIFO buffering UDP payload, with registered read data and a one-cycle flush
`timescale 1ns/100ps

module byte_fifo (
  input  logic       clk,
  input  logic       rst,
  input  logic       flush,
  input  logic       write,
  input  logic [7:0] data_in,
  input  logic       read,
  output logic [7:0] data_out,
  output logic       empty,
  output logic       full
);

  logic [7:0] mem [udp_tx_pkg::FIFO_DEPTH];

  logic [$clog2(udp_tx_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(udp_tx_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(udp_tx_pkg::FIFO_DEPTH+1)-1:0] count;
  logic wr_en;
  logic rd_en;

  // requests against a full or empty buffer are simply ignored
  assign wr_en = write && !full;
  assign rd_en = read && !empty;

  // flags come straight from the occupancy register
  assign empty = (count == 0);
  assign full  = (count == udp_tx_pkg::FIFO_DEPTH);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == udp_tx_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == udp_tx_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_in;
    end
    if (rd_en) begin
      data_out <= mem[rd_ptr];
    end
  end

endmodule

// ==== design/udp_tx_cfg.sv ====
// register block for the UDP transmitter, written by strobe and read by the controller as levels
`timescale 1ns/100ps

module udp_tx_cfg (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfg_we,
  input  udp_tx_pkg::cfg_addr_t  cfg_addr,
  input  logic [31:0]            cfg_wdata,
  output udp_tx_pkg::ipv4_addr_t dev_ip,
  output udp_tx_pkg::ipv4_addr_t rem_ip,
  output udp_tx_pkg::port_t      loc_port,
  output udp_tx_pkg::port_t      rem_port,
  output udp_tx_pkg::len_t       length
);

  always_ff @(posedge clk) begin
    if (rst) begin
      dev_ip   <= '0;
      rem_ip   <= '0;
      loc_port <= '0;
      rem_port <= '0;
      length   <= '0;
    end else if (cfg_we) begin
      // ports and length are 16 bit, so only the low half of the write data is kept
      case (cfg_addr)
        udp_tx_pkg::REG_DEV_IP: begin
          dev_ip <= cfg_wdata;
        end
        udp_tx_pkg::REG_REM_IP: begin
          rem_ip <= cfg_wdata;
        end
        udp_tx_pkg::REG_LOC_PORT: begin
          loc_port <= cfg_wdata[15:0];
        end
        udp_tx_pkg::REG_REM_PORT: begin
          rem_port <= cfg_wdata[15:0];
        end
        udp_tx_pkg::REG_LENGTH: begin
          length <= cfg_wdata[15:0];
        end
        default: begin
          // unmapped addresses are dropped
        end
      endcase
    end
  end

endmodule

// ==== udp_tx_ctl/udp_tx_ctl.sv ====
// UDP transmit controller that latches a descriptor, serializes the header and streams the payload
`timescale 1ns/100ps

module udp_tx_ctl (
  input  logic                   clk,
  input  logic                   rst,
  input  udp_tx_pkg::ipv4_addr_t dev_ip,
  input  udp_tx_pkg::ipv4_addr_t rem_ip,
  input  udp_tx_pkg::port_t      loc_port,
  input  udp_tx_pkg::port_t      rem_port,
  input  udp_tx_pkg::len_t       length,
  input  logic [7:0]             in_dat,
  input  logic                   in_val,
  input  logic                   req,
  input  logic [7:0]             fifo_data,
  input  logic                   fifo_empty,
  input  logic                   fifo_full,
  output logic                   cts,
  output logic                   rdy,
  output logic [7:0]             out_dat,
  output logic                   out_sof,
  output logic                   out_eof,
  output logic                   out_val,
  output udp_tx_pkg::ipv4_addr_t hdr_src_ip,
  output udp_tx_pkg::ipv4_addr_t hdr_dst_ip,
  output udp_tx_pkg::ipv4_id_t   hdr_ip_id,
  output logic                   fifo_write,
  output logic [7:0]             fifo_wdata,
  output logic                   fifo_read,
  output logic                   fifo_flush
);

  typedef enum logic [1:0] {
    idle_s,
    pend_s,
    tx_s
  } state_t;

  state_t state;

  logic [udp_tx_pkg::CTR_W-1:0] ctr;
  udp_tx_pkg::ipv4_id_t         ip_id;

  // datagram descriptor, frozen while pending and transmitting
  udp_tx_pkg::port_t src_port;
  udp_tx_pkg::port_t dst_port;
  udp_tx_pkg::len_t  pay_len;
  udp_tx_pkg::len_t  udp_len;

  udp_tx_pkg::len_t clamp_len;
  logic             last_beat;

  // UDP length counts the header too, so the clamp applies to the payload only
  assign clamp_len = (length <= udp_tx_pkg::len_t'(udp_tx_pkg::UDP_MAX_PAYLOAD)) ?
                     length : udp_tx_pkg::len_t'(udp_tx_pkg::UDP_MAX_PAYLOAD);

  assign last_beat = (state == tx_s) && (ctr == udp_len - 1'b1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle_s;
      ctr   <= '0;
      ip_id <= '0;
    end else begin
      case (state)
        idle_s: begin
          ctr <= '0;
          if (!fifo_empty) begin
            state <= pend_s;
            ip_id <= ip_id + 1'b1;
          end
        end
        pend_s: begin
          if (req) begin
            state <= tx_s;
          end
        end
        tx_s: begin
          ctr <= ctr + 1'b1;
          if (last_beat) begin
            state <= idle_s;
          end
        end
        default: begin
          state <= idle_s;
        end
      endcase
    end
  end

  // the descriptor tracks the configuration only while idle
  always_ff @(posedge clk) begin
    if (state == idle_s) begin
      src_port   <= loc_port;
      dst_port   <= rem_port;
      pay_len    <= clamp_len;
      udp_len    <= clamp_len + udp_tx_pkg::len_t'(udp_tx_pkg::UDP_HDR_LEN);
      hdr_src_ip <= dev_ip;
      hdr_dst_ip <= rem_ip;
    end
  end

  assign hdr_ip_id = ip_id;

  assign rdy = (state == pend_s);
  assign cts = (state != tx_s);

  assign fifo_write = in_val && cts && !fifo_full;
  assign fifo_wdata = in_dat;

  // read one beat early because the FIFO output is registered
  assign fifo_read = (state == tx_s) &&
                     (ctr >= udp_tx_pkg::UDP_HDR_LEN - 1) &&
                     (ctr < pay_len + udp_tx_pkg::UDP_HDR_LEN - 1);

  // leftover bytes beyond the clamped length are discarded with the last beat
  assign fifo_flush = last_beat;

  assign out_val = (state == tx_s);
  assign out_sof = (state == tx_s) && (ctr == '0);
  assign out_eof = last_beat;

  // header fields go out most significant byte first, checksum left at zero
  always_comb begin
    case (ctr)
      'd0:     out_dat = src_port[15:8];
      'd1:     out_dat = src_port[7:0];
      'd2:     out_dat = dst_port[15:8];
      'd3:     out_dat = dst_port[7:0];
      'd4:     out_dat = udp_len[15:8];
      'd5:     out_dat = udp_len[7:0];
      'd6:     out_dat = 8'h00;
      'd7:     out_dat = 8'h00;
      default: out_dat = fifo_data;
    endcase
  end

endmodule

// ==== design/udp_tx_top.sv ====
// top level of the UDP transmitter joining the register block, the payload FIFO and the controller
`timescale 1ns/100ps

module udp_tx_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfg_we,
  input  udp_tx_pkg::cfg_addr_t  cfg_addr,
  input  logic [31:0]            cfg_wdata,
  input  logic [7:0]             in_dat,
  input  logic                   in_val,
  input  logic                   req,
  output logic                   cts,
  output logic                   rdy,
  output logic [7:0]             out_dat,
  output logic                   out_sof,
  output logic                   out_eof,
  output logic                   out_val,
  output udp_tx_pkg::ipv4_addr_t hdr_src_ip,
  output udp_tx_pkg::ipv4_addr_t hdr_dst_ip,
  output udp_tx_pkg::ipv4_id_t   hdr_ip_id
);

  udp_tx_pkg::ipv4_addr_t dev_ip;
  udp_tx_pkg::ipv4_addr_t rem_ip;
  udp_tx_pkg::port_t      loc_port;
  udp_tx_pkg::port_t      rem_port;
  udp_tx_pkg::len_t       length;

  logic       fifo_write;
  logic [7:0] fifo_wdata;
  logic       fifo_read;
  logic       fifo_flush;
  logic [7:0] fifo_data;
  logic       fifo_empty;
  logic       fifo_full;

  udp_tx_cfg u_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .dev_ip    (dev_ip),
    .rem_ip    (rem_ip),
    .loc_port  (loc_port),
    .rem_port  (rem_port),
    .length    (length)
  );

  byte_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .flush    (fifo_flush),
    .write    (fifo_write),
    .data_in  (fifo_wdata),
    .read     (fifo_read),
    .data_out (fifo_data),
    .empty    (fifo_empty),
    .full     (fifo_full)
  );

  udp_tx_ctl u_ctl (
    .clk        (clk),
    .rst        (rst),
    .dev_ip     (dev_ip),
    .rem_ip     (rem_ip),
    .loc_port   (loc_port),
    .rem_port   (rem_port),
    .length     (length),
    .in_dat     (in_dat),
    .in_val     (in_val),
    .req        (req),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .cts        (cts),
    .rdy        (rdy),
    .out_dat    (out_dat),
    .out_sof    (out_sof),
    .out_eof    (out_eof),
    .out_val    (out_val),
    .hdr_src_ip (hdr_src_ip),
    .hdr_dst_ip (hdr_dst_ip),
    .hdr_ip_id  (hdr_ip_id),
    .fifo_write (fifo_write),
    .fifo_wdata (fifo_wdata),
    .fifo_read  (fifo_read),
    .fifo_flush (fifo_flush)
  );

endmodule

// ==== tests/udp_tx_tb.sv ====
// testbench for the UDP transmitter that replays the vector file and checks every streamed datagram
`timescale 1ns/100ps

module udp_tx_tb;

  localparam int TIMEOUT_CYCLES = 200;

  logic                   clk;
  logic                   rst;
  logic                   cfg_we;
  udp_tx_pkg::cfg_addr_t  cfg_addr;
  logic [31:0]            cfg_wdata;
  logic [7:0]             in_dat;
  logic                   in_val;
  logic                   req;
  logic                   cts;
  logic                   rdy;
  logic [7:0]             out_dat;
  logic                   out_sof;
  logic                   out_eof;
  logic                   out_val;
  udp_tx_pkg::ipv4_addr_t hdr_src_ip;
  udp_tx_pkg::ipv4_addr_t hdr_dst_ip;
  udp_tx_pkg::ipv4_id_t   hdr_ip_id;

  logic [31:0] gen_state;
  logic [31:0] junk_state;
  logic [7:0]  exp_q[$];
  logic [7:0]  rx_q[$];
  int unsigned dgram_cnt;

  udp_tx_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .in_dat     (in_dat),
    .in_val     (in_val),
    .req        (req),
    .cts        (cts),
    .rdy        (rdy),
    .out_dat    (out_dat),
    .out_sof    (out_sof),
    .out_eof    (out_eof),
    .out_val    (out_val),
    .hdr_src_ip (hdr_src_ip),
    .hdr_dst_ip (hdr_dst_ip),
    .hdr_ip_id  (hdr_ip_id)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compare_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_port(input string name, input udp_tx_pkg::port_t expected,
                              input udp_tx_pkg::port_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_len(input string name, input udp_tx_pkg::len_t expected,
                             input udp_tx_pkg::len_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_ip(input string name, input udp_tx_pkg::ipv4_addr_t expected,
                            input udp_tx_pkg::ipv4_addr_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_id(input string name, input udp_tx_pkg::ipv4_id_t expected,
                            input udp_tx_pkg::ipv4_id_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic write_reg(input udp_tx_pkg::cfg_addr_t addr, input logic [31:0] data);
    @(negedge clk);
    compare_flag("out_val", 1'b0, out_val);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic push_bytes(input int unsigned n);
    int unsigned i;
    int unsigned held;
    held = 0;
    for (i = 0; i < n; i++) begin
      @(negedge clk);
      compare_flag("out_val", 1'b0, out_val);
      compare_flag("cts", 1'b1, cts);
      gen_state = lcg_next(gen_state);
      in_dat    = gen_state[23:16];
      in_val    = 1'b1;
      // the FIFO starts every datagram empty and drops writes once it is full
      if (held < udp_tx_pkg::FIFO_DEPTH) begin
        exp_q.push_back(gen_state[23:16]);
        held++;
      end
    end
    @(negedge clk);
    in_val = 1'b0;
  endtask

  task automatic wait_rdy();
    int unsigned cycles;
    cycles = 0;
    while (rdy !== 1'b1) begin
      compare_flag("out_val", 1'b0, out_val);
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("timed out waiting for rdy to rise");
      end
    end
  endtask

  task automatic collect_beats(input udp_tx_pkg::ipv4_addr_t src_ip,
                               input udp_tx_pkg::ipv4_addr_t dst_ip,
                               input udp_tx_pkg::ipv4_id_t id);
    int unsigned cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    rx_q.delete();
    while (!done) begin
      compare_flag("out_val", 1'b1, out_val);
      compare_flag("out_sof", rx_q.size() == 0, out_sof);
      compare_flag("cts", 1'b0, cts);
      compare_ip("hdr_src_ip", src_ip, hdr_src_ip);
      compare_ip("hdr_dst_ip", dst_ip, hdr_dst_ip);
      compare_id("hdr_ip_id", id, hdr_ip_id);
      rx_q.push_back(out_dat);
      done = out_eof;
      // bytes offered during the stream must never reach the FIFO
      junk_state = lcg_next(junk_state);
      in_dat     = junk_state[23:16];
      in_val     = !done;
      if (!done) begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
          abort_run("timed out waiting for the end of the datagram");
        end
      end
    end
    in_val = 1'b0;
  endtask

  task automatic run_datagram(input logic [31:0] dev_ip, input logic [31:0] rem_ip,
                              input logic [31:0] loc_port, input logic [31:0] rem_port,
                              input logic [31:0] length, input logic [31:0] n,
                              input logic [31:0] seed);
    udp_tx_pkg::len_t pay_len;
    int unsigned      i;
    // registers keep only the low 16 bits of ports and length
    if (length[15:0] <= udp_tx_pkg::UDP_MAX_PAYLOAD) begin
      pay_len = length[15:0];
    end else begin
      pay_len = udp_tx_pkg::len_t'(udp_tx_pkg::UDP_MAX_PAYLOAD);
    end
    dgram_cnt++;
    exp_q.delete();
    gen_state = lcg_next(gen_state + seed);
    write_reg(udp_tx_pkg::REG_DEV_IP, dev_ip);
    write_reg(udp_tx_pkg::REG_REM_IP, rem_ip);
    write_reg(udp_tx_pkg::REG_LOC_PORT, loc_port);
    write_reg(udp_tx_pkg::REG_REM_PORT, rem_port);
    write_reg(udp_tx_pkg::REG_LENGTH, length);
    push_bytes(n);
    wait_rdy();
    compare_ip("hdr_src_ip", dev_ip, hdr_src_ip);
    compare_ip("hdr_dst_ip", rem_ip, hdr_dst_ip);
    compare_id("hdr_ip_id", udp_tx_pkg::ipv4_id_t'(dgram_cnt), hdr_ip_id);
    req = 1'b1;
    @(negedge clk);
    req = 1'b0;
    compare_flag("rdy", 1'b0, rdy);
    collect_beats(dev_ip, rem_ip, udp_tx_pkg::ipv4_id_t'(dgram_cnt));
    @(negedge clk);
    compare_flag("cts", 1'b1, cts);
    compare_flag("out_val", 1'b0, out_val);
    compare_len("beat count", pay_len + 16'd8, udp_tx_pkg::len_t'(rx_q.size()));
    compare_port("udp source port", loc_port[15:0], {rx_q[0], rx_q[1]});
    compare_port("udp destination port", rem_port[15:0], {rx_q[2], rx_q[3]});
    compare_len("udp length", pay_len + 16'd8, {rx_q[4], rx_q[5]});
    compare_byte("udp checksum high", 8'h00, rx_q[6]);
    compare_byte("udp checksum low", 8'h00, rx_q[7]);
    for (i = 0; i < pay_len; i++) begin
      compare_byte($sformatf("payload[%0d]", i), exp_q[i], rx_q[8 + i]);
    end
  endtask

  initial begin
    int          fd;
    int          rc;
    int          n_fields;
    string       line;
    logic [31:0] f_dev;
    logic [31:0] f_rem;
    logic [31:0] f_lport;
    logic [31:0] f_rport;
    logic [31:0] f_len;
    logic [31:0] f_num;
    logic [31:0] f_seed;
    rst        = 1'b1;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    in_dat     = '0;
    in_val     = 1'b0;
    req        = 1'b0;
    gen_state  = 32'd224;
    junk_state = lcg_next(32'd224);
    dgram_cnt  = 0;
    // ten rising edges with reset high, then release on the falling edge
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    compare_flag("rdy", 1'b0, rdy);
    compare_flag("out_val", 1'b0, out_val);
    compare_flag("out_sof", 1'b0, out_sof);
    compare_flag("out_eof", 1'b0, out_eof);
    compare_flag("cts", 1'b1, cts);
    compare_id("hdr_ip_id", 16'h0000, hdr_ip_id);
    fd = $fopen("tests/udp_tx_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the vector file");
    end
    while (!$feof(fd)) begin
      line = "";
      rc   = $fgets(line, fd);
      if (rc > 0 && line.getc(0) != "#") begin
        n_fields = $sscanf(line, "%h %h %h %h %h %h %h",
                           f_dev, f_rem, f_lport, f_rport, f_len, f_num, f_seed);
        if (n_fields == 7) begin
          run_datagram(f_dev, f_rem, f_lport, f_rport, f_len, f_num, f_seed);
        end else if (n_fields > 0) begin
          abort_run("found a malformed line in the vector file");
        end
      end
    end
    $fclose(fd);
    if (dgram_cnt == 0) begin
      abort_run("the vector file held no datagrams");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== tests/udp_tx_vectors.txt ====
# dev_ip rem_ip loc_port rem_port length count seed, all in hex, one datagram per line
# length is the requested payload, count is how many bytes are pushed into the FIFO
c0a80001 c0a80002 1f90 0035 10 10 1
0a000001 0a0000fe 04d2 162e 4 6 2a
# 50 requested and pushed, clamped to 36, the 14 left over are flushed
ac100001 ac1000ff 3039 d431 32 32 7
ac100001 ac1000ff 3039 d431 8 8 13
# 70 pushed, only 64 fit
c0a80101 c0a801c8 0400 0401 20 46 5
c0a80101 c0a801c8 0400 0401 0 3 99
ffffffff 00000000 ffff 0000 24 24 ff
# upper halves of ports and length are not stored
01020304 05060708 0001abcd 5678abcd 00010005 9 3c
7f000001 7f000001 0007 0007 ffff 40 44
0a0a0a0a 0b0b0b0b 8000 8001 1 1 1e
c0a80a01 c0a80a02 1388 1389 25 30 b7

// ==== udp_tx.f ====
common/udp_tx_pkg.sv
design/byte_fifo.sv
design/udp_tx_cfg.sv
udp_tx_ctl/udp_tx_ctl.sv
design/udp_tx_top.sv
tests/udp_tx_tb.sv

// ==== run_udp_tx.sh ====
#!/bin/sh
# compiles the UDP transmitter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module udp_tx_tb \
    --Mdir obj_dir -f udp_tx.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vudp_tx_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '>>> FAIL' "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation finished without failures"
exit 0
